// ==== src/tile_pkg.sv ====
package tile_pkg;

    // noc word and address layout
    localparam int NOC_DATA_W = 32;
    localparam int NOC_BSEL_W = NOC_DATA_W / 8;
    localparam int NOC_ADDR_W = 32;

    // scratchpad, word address from byte address bits 9:2
    localparam int SPM_DEPTH  = 256;
    localparam int SPM_ADDR_W = $clog2(SPM_DEPTH);

    // packet modes
    localparam int NOC_MODE_W = 3;
    localparam logic [NOC_MODE_W-1:0] MODE_MEM_WRITE = 3'd0;
    localparam logic [NOC_MODE_W-1:0] MODE_MEM_READ  = 3'd1;
    localparam logic [NOC_MODE_W-1:0] MODE_READ_RESP = 3'd2;
    localparam logic [NOC_MODE_W-1:0] MODE_REG_WRITE = 3'd3;
    localparam logic [NOC_MODE_W-1:0] MODE_REG_READ  = 3'd4;

    // tile registers, index from byte address bits 3:2
    localparam int REG_ADDR_W = 2;
    localparam logic [REG_ADDR_W-1:0] REG_CORE_EN  = 2'd0;
    localparam logic [REG_ADDR_W-1:0] REG_EXT_INT  = 2'd1;
    localparam logic [REG_ADDR_W-1:0] REG_LAST_SRC = 2'd2;

    localparam int NUM_EXT_INT = 2;

    // chip coordinates
    localparam int CHIPID_W = 8;
    localparam int CHIP_X_W = 3;
    localparam int CHIP_Y_W = 3;
    localparam int CHIP_Z_W = 2;

    // noc controller states
    localparam int CTRL_ST_W = 2;
    localparam logic [CTRL_ST_W-1:0] ST_IDLE     = 2'd0;
    localparam logic [CTRL_ST_W-1:0] ST_SPM_REQ  = 2'd1;
    localparam logic [CTRL_ST_W-1:0] ST_SPM_WAIT = 2'd2;
    localparam logic [CTRL_ST_W-1:0] ST_TX       = 2'd3;

    // x in the upper bits, z in the lowest
    typedef union packed {
        logic [CHIPID_W-1:0] id;
        struct packed {
            logic [CHIP_X_W-1:0] x;
            logic [CHIP_Y_W-1:0] y;
            logic [CHIP_Z_W-1:0] z;
        } coord;
    } chip_id_u;

endpackage

// ==== src/tile_ifs.sv ====
`timescale 1ns/1ps

// single-word memory port, addr is a byte address
interface spm_port_if;
    import tile_pkg::*;

    logic                  en;
    logic [NOC_BSEL_W-1:0] wben;   // all zero means read
    logic [NOC_ADDR_W-1:0] addr;
    logic [NOC_DATA_W-1:0] wdata;
    logic [NOC_DATA_W-1:0] rdata;  // valid one cycle after acceptance
    logic                  stall;

    modport requester (
        output en, wben, addr, wdata,
        input  rdata, stall
    );

    modport memory (
        input  en, wben, addr, wdata,
        output rdata, stall
    );

endinterface

// tile register access, one cycle, rdata combinational on idx
interface cfg_port_if;
    import tile_pkg::*;

    logic                  en;
    logic                  we;
    logic [REG_ADDR_W-1:0] idx;
    logic [NOC_DATA_W-1:0] wdata;
    logic [NOC_DATA_W-1:0] rdata;

    modport master (
        output en, we, idx, wdata,
        input  rdata
    );

    modport slave (
        input  en, we, idx, wdata,
        output rdata
    );

endinterface

// ==== src/spm_mem.sv ====
`timescale 1ns/1ps

module spm_mem (
    input  logic       clk_pm_i,
    spm_port_if.memory bus
);
    import tile_pkg::*;

    logic [NOC_DATA_W-1:0] mem_q [SPM_DEPTH];
    logic [SPM_ADDR_W-1:0] word_addr;
    logic [NOC_DATA_W-1:0] rdata_q;

    assign word_addr = bus.addr[SPM_ADDR_W+1:2];  // upper bits ignored
    assign bus.stall = 1'b0;                      // never busy

    always_ff @(posedge clk_pm_i) begin
        if (bus.en) begin
            for (int b = 0; b < NOC_BSEL_W; b++) begin
                if (bus.wben[b]) begin
                    mem_q[word_addr][8*b +: 8] <= bus.wdata[8*b +: 8];
                end
            end
            rdata_q <= mem_q[word_addr];  // old data on a write
        end
    end

    assign bus.rdata = rdata_q;

endmodule

// ==== src/spm_arbiter.sv ====
`timescale 1ns/1ps

module spm_arbiter (
    input  logic          clk_pm_i,
    input  logic          arst_n_i,
    spm_port_if.memory    noc,
    spm_port_if.memory    core,
    spm_port_if.requester mem
);

    logic gnt_core;     // core owns the memory this cycle
    logic last_core_q;  // core got the last accepted access

    // on a conflict the port not granted last wins
    always_comb begin
        if (noc.en && core.en) begin
            gnt_core = ~last_core_q;
        end else begin
            gnt_core = core.en;
        end
    end

    assign mem.en    = noc.en | core.en;
    assign mem.wben  = gnt_core ? core.wben  : noc.wben;
    assign mem.addr  = gnt_core ? core.addr  : noc.addr;
    assign mem.wdata = gnt_core ? core.wdata : noc.wdata;

    // loser holds its request
    assign noc.stall  = mem.stall | gnt_core;
    assign core.stall = mem.stall | (noc.en & ~gnt_core);

    always_ff @(posedge clk_pm_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            last_core_q <= 1'b0;
        end else if (mem.en && !mem.stall) begin
            last_core_q <= gnt_core;
        end
    end

    // read data arrives one cycle later, so last_core_q still names its owner
    assign noc.rdata  = last_core_q ? '0 : mem.rdata;
    assign core.rdata = last_core_q ? mem.rdata : '0;

endmodule

// ==== src/tile_regfile.sv ====
`timescale 1ns/1ps

module tile_regfile (
    input  logic                             clk_pm_i,
    input  logic                             arst_n_i,
    cfg_port_if.slave                        cfg,
    input  tile_pkg::chip_id_u               last_src_i,
    output logic                             core_en_o,
    output logic [tile_pkg::NUM_EXT_INT-1:0] ext_int_o
);
    import tile_pkg::*;

    logic                   core_en_q;
    logic [NUM_EXT_INT-1:0] ext_int_q;
    chip_id_u               last_src_q;

    always_ff @(posedge clk_pm_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            core_en_q  <= 1'b0;
            ext_int_q  <= '0;
            last_src_q <= '0;
        end else begin
            ext_int_q <= '0;  // pulses last one cycle
            if (cfg.en) begin
                last_src_q <= last_src_i;
            end
            if (cfg.en && cfg.we) begin
                case (cfg.idx)
                    REG_CORE_EN: core_en_q <= cfg.wdata[0];
                    REG_EXT_INT: ext_int_q <= cfg.wdata[NUM_EXT_INT-1:0];
                    default: ;
                endcase
            end
        end
    end

    // the access itself loads last_src, so a read shows the previous requester
    always_comb begin
        cfg.rdata = '0;
        case (cfg.idx)
            REG_CORE_EN: cfg.rdata[0] = core_en_q;
            REG_LAST_SRC: begin
                cfg.rdata[CHIP_X_W-1:0]  = last_src_q.coord.x;
                cfg.rdata[8 +: CHIP_Y_W]  = last_src_q.coord.y;
                cfg.rdata[16 +: CHIP_Z_W] = last_src_q.coord.z;
            end
            default: ;  // ext int and index 3 read zero
        endcase
    end

    assign core_en_o = core_en_q;
    assign ext_int_o = ext_int_q;

endmodule

// ==== src/noc_mem_ctrl.sv ====
`timescale 1ns/1ps

module noc_mem_ctrl (
    input  logic                            clk_pm_i,
    input  logic                            arst_n_i,
    input  tile_pkg::chip_id_u              home_chipid_i,

    input  logic                            rx_wrreq_i,
    input  logic [tile_pkg::NOC_MODE_W-1:0] rx_mode_i,
    input  logic [tile_pkg::NOC_ADDR_W-1:0] rx_addr_i,
    input  logic [tile_pkg::NOC_BSEL_W-1:0] rx_bsel_i,
    input  logic [tile_pkg::NOC_DATA_W-1:0] rx_data_i,
    input  tile_pkg::chip_id_u              rx_src_chipid_i,
    input  tile_pkg::chip_id_u              rx_trg_chipid_i,
    output logic                            rx_stall_o,

    output logic                            tx_wrreq_o,
    output logic [tile_pkg::NOC_MODE_W-1:0] tx_mode_o,
    output logic [tile_pkg::NOC_ADDR_W-1:0] tx_addr_o,
    output logic [tile_pkg::NOC_DATA_W-1:0] tx_data_o,
    output tile_pkg::chip_id_u              tx_trg_chipid_o,
    output tile_pkg::chip_id_u              tx_src_chipid_o,
    input  logic                            tx_stall_i,

    spm_port_if.requester                   spm,
    cfg_port_if.master                      cfg
);
    import tile_pkg::*;

    logic [CTRL_ST_W-1:0]  state_q;
    logic [CTRL_ST_W-1:0]  state_d;
    logic                  accept;
    logic                  for_home;
    logic                  is_reg;
    logic                  rd_q;      // pending spm access is a read
    logic [NOC_ADDR_W-1:0] addr_q;
    logic [NOC_BSEL_W-1:0] bsel_q;
    logic [NOC_DATA_W-1:0] data_q;    // write data, later response data
    chip_id_u              src_q;

    assign rx_stall_o = (state_q != ST_IDLE);
    assign accept     = rx_wrreq_i & ~rx_stall_o;
    assign for_home   = (rx_trg_chipid_i.id == home_chipid_i.id);

    // register flits are served in the cycle they are taken
    assign is_reg    = (rx_mode_i == MODE_REG_WRITE) | (rx_mode_i == MODE_REG_READ);
    assign cfg.en    = accept & for_home & is_reg;
    assign cfg.we    = (rx_mode_i == MODE_REG_WRITE);
    assign cfg.idx   = rx_addr_i[REG_ADDR_W+1:2];
    assign cfg.wdata = rx_data_i;

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (accept && for_home) begin
                    case (rx_mode_i)
                        MODE_MEM_WRITE,
                        MODE_MEM_READ: state_d = ST_SPM_REQ;
                        MODE_REG_READ: state_d = ST_TX;
                        default:       state_d = ST_IDLE;  // reg write done, stray responses
                    endcase
                end
            end
            ST_SPM_REQ: begin
                if (!spm.stall) begin
                    state_d = rd_q ? ST_SPM_WAIT : ST_IDLE;
                end
            end
            ST_SPM_WAIT: state_d = ST_TX;
            ST_TX: begin
                if (!tx_stall_i) begin
                    state_d = ST_IDLE;
                end
            end
            default: state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk_pm_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= ST_IDLE;
            rd_q    <= 1'b0;
        end else begin
            state_q <= state_d;
            if (accept) begin
                rd_q <= (rx_mode_i == MODE_MEM_READ);
            end
        end
    end

    always_ff @(posedge clk_pm_i) begin
        if (accept) begin
            addr_q <= rx_addr_i;
            bsel_q <= rx_bsel_i;
            src_q  <= rx_src_chipid_i;
            data_q <= (rx_mode_i == MODE_REG_READ) ? cfg.rdata : rx_data_i;
        end else if (state_q == ST_SPM_WAIT) begin
            data_q <= spm.rdata;
        end
    end

    assign spm.en    = (state_q == ST_SPM_REQ);
    assign spm.wben  = rd_q ? '0 : bsel_q;
    assign spm.addr  = addr_q;
    assign spm.wdata = data_q;

    // response goes back to the requesting chip
    assign tx_wrreq_o      = (state_q == ST_TX);
    assign tx_mode_o       = MODE_READ_RESP;
    assign tx_addr_o       = addr_q;
    assign tx_data_o       = data_q;
    assign tx_trg_chipid_o = src_q;
    assign tx_src_chipid_o = home_chipid_i;

endmodule

// ==== src/tile_top.sv ====
`timescale 1ns/1ps

module tile_top (
    input  logic                             clk_pm_i,
    input  logic                             arst_n_i,
    input  tile_pkg::chip_id_u               home_chipid_i,

    input  logic                             rx_wrreq_i,
    input  logic [tile_pkg::NOC_MODE_W-1:0]  rx_mode_i,
    input  logic [tile_pkg::NOC_ADDR_W-1:0]  rx_addr_i,
    input  logic [tile_pkg::NOC_BSEL_W-1:0]  rx_bsel_i,
    input  logic [tile_pkg::NOC_DATA_W-1:0]  rx_data_i,
    input  tile_pkg::chip_id_u               rx_src_chipid_i,
    input  tile_pkg::chip_id_u               rx_trg_chipid_i,
    output logic                             rx_stall_o,

    output logic                             tx_wrreq_o,
    output logic [tile_pkg::NOC_MODE_W-1:0]  tx_mode_o,
    output logic [tile_pkg::NOC_ADDR_W-1:0]  tx_addr_o,
    output logic [tile_pkg::NOC_DATA_W-1:0]  tx_data_o,
    output tile_pkg::chip_id_u               tx_trg_chipid_o,
    output tile_pkg::chip_id_u               tx_src_chipid_o,
    input  logic                             tx_stall_i,

    input  logic                             core_mem_en_i,
    input  logic [tile_pkg::NOC_BSEL_W-1:0]  core_mem_wben_i,
    input  logic [tile_pkg::NOC_ADDR_W-1:0]  core_mem_addr_i,
    input  logic [tile_pkg::NOC_DATA_W-1:0]  core_mem_wdata_i,
    output logic [tile_pkg::NOC_DATA_W-1:0]  core_mem_rdata_o,
    output logic                             core_mem_stall_o,

    output logic                             core_en_o,
    output logic [tile_pkg::NUM_EXT_INT-1:0] ext_int_o
);

    spm_port_if noc_spm ();
    spm_port_if core_spm ();
    spm_port_if spm_bus ();
    cfg_port_if cfg ();

    // core side of the scratchpad
    assign core_spm.en      = core_mem_en_i;
    assign core_spm.wben    = core_mem_wben_i;
    assign core_spm.addr    = core_mem_addr_i;
    assign core_spm.wdata   = core_mem_wdata_i;
    assign core_mem_rdata_o = core_spm.rdata;
    assign core_mem_stall_o = core_spm.stall;

    noc_mem_ctrl i_noc_mem_ctrl (
        .clk_pm_i        (clk_pm_i),
        .arst_n_i        (arst_n_i),
        .home_chipid_i   (home_chipid_i),
        .rx_wrreq_i      (rx_wrreq_i),
        .rx_mode_i       (rx_mode_i),
        .rx_addr_i       (rx_addr_i),
        .rx_bsel_i       (rx_bsel_i),
        .rx_data_i       (rx_data_i),
        .rx_src_chipid_i (rx_src_chipid_i),
        .rx_trg_chipid_i (rx_trg_chipid_i),
        .rx_stall_o      (rx_stall_o),
        .tx_wrreq_o      (tx_wrreq_o),
        .tx_mode_o       (tx_mode_o),
        .tx_addr_o       (tx_addr_o),
        .tx_data_o       (tx_data_o),
        .tx_trg_chipid_o (tx_trg_chipid_o),
        .tx_src_chipid_o (tx_src_chipid_o),
        .tx_stall_i      (tx_stall_i),
        .spm             (noc_spm.requester),
        .cfg             (cfg.master)
    );

    spm_arbiter i_spm_arbiter (
        .clk_pm_i (clk_pm_i),
        .arst_n_i (arst_n_i),
        .noc      (noc_spm.memory),
        .core     (core_spm.memory),
        .mem      (spm_bus.requester)
    );

    spm_mem i_spm_mem (
        .clk_pm_i (clk_pm_i),
        .bus      (spm_bus.memory)
    );

    tile_regfile i_tile_regfile (
        .clk_pm_i   (clk_pm_i),
        .arst_n_i   (arst_n_i),
        .cfg        (cfg.slave),
        .last_src_i (rx_src_chipid_i),  // loaded on each register access
        .core_en_o  (core_en_o),
        .ext_int_o  (ext_int_o)
    );

endmodule

// ==== testbench/tb_model.svh ====
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// model scratchpad and tile registers, updated at flit or core acceptance
logic [NOC_DATA_W-1:0] model_spm [SPM_DEPTH];
bit                    touched [SPM_DEPTH];
logic                  model_core_en;
logic [CHIPID_W-1:0]   model_last_src;

function automatic logic [SPM_ADDR_W-1:0] word_of(input logic [NOC_ADDR_W-1:0] addr);
    return addr[9:2];  // upper address bits are ignored
endfunction

function automatic void merge_write(input logic [NOC_ADDR_W-1:0] addr,
                                    input logic [NOC_BSEL_W-1:0] bsel,
                                    input logic [NOC_DATA_W-1:0] data);
    logic [SPM_ADDR_W-1:0] w;
    w = word_of(addr);
    for (int b = 0; b < NOC_BSEL_W; b++) begin
        if (bsel[b]) begin
            model_spm[w][8*b +: 8] = data[8*b +: 8];
        end
    end
    touched[w] = 1'b1;
endfunction

// register side effects of a home flit
function automatic void apply_reg_flit(input logic [NOC_MODE_W-1:0] mode,
                                       input logic [NOC_ADDR_W-1:0] addr,
                                       input logic [NOC_DATA_W-1:0] data,
                                       input logic [CHIPID_W-1:0]   src);
    if (mode == MODE_REG_WRITE || mode == MODE_REG_READ) begin
        if (mode == MODE_REG_WRITE && addr[3:2] == REG_CORE_EN) begin
            model_core_en = data[0];
        end
        model_last_src = src;  // a read still shows the previous requester
    end
endfunction

function automatic logic [NOC_DATA_W-1:0] expected_read(input logic [NOC_MODE_W-1:0] mode,
                                                        input logic [NOC_ADDR_W-1:0] addr);
    logic [NOC_DATA_W-1:0] r;
    r = '0;
    if (mode == MODE_MEM_READ) begin
        r = model_spm[word_of(addr)];
    end else if (addr[3:2] == REG_CORE_EN) begin
        r[0] = model_core_en;
    end else if (addr[3:2] == REG_LAST_SRC) begin
        r[2:0]   = model_last_src[7:5];  // x
        r[10:8]  = model_last_src[4:2];  // y
        r[17:16] = model_last_src[1:0];  // z
    end
    return r;
endfunction

`endif

// ==== testbench/tb_tile_top.sv ====
`timescale 1ns/1ps

module tb_tile_top;
    import tile_pkg::*;

    localparam int CLK_PERIOD = 8;
    localparam logic [CHIPID_W-1:0] HOME_ID  = 8'hAE;  // x 5, y 3, z 2
    localparam logic [CHIPID_W-1:0] OTHER_ID = 8'hAF;
    // cycle budget of reset and each test
    localparam int RUN_CYCLES = 8 + 400 + 300 + 1500 + 250 + 200 + 100;

    logic                  clk_pm;
    logic                  arst_n;
    chip_id_u              home;
    logic                  rx_wrreq;
    logic [NOC_MODE_W-1:0] rx_mode;
    logic [NOC_ADDR_W-1:0] rx_addr;
    logic [NOC_BSEL_W-1:0] rx_bsel;
    logic [NOC_DATA_W-1:0] rx_data;
    chip_id_u              rx_src;
    chip_id_u              rx_trg;
    logic                  rx_stall;
    logic                  tx_wrreq;
    logic [NOC_MODE_W-1:0] tx_mode;
    logic [NOC_ADDR_W-1:0] tx_addr;
    logic [NOC_DATA_W-1:0] tx_data;
    chip_id_u              tx_trg;
    chip_id_u              tx_src;
    logic                  tx_stall;
    logic                  core_mem_en;
    logic [NOC_BSEL_W-1:0] core_mem_wben;
    logic [NOC_ADDR_W-1:0] core_mem_addr;
    logic [NOC_DATA_W-1:0] core_mem_wdata;
    logic [NOC_DATA_W-1:0] core_mem_rdata;
    logic                  core_mem_stall;
    logic                  core_en;
    logic [NUM_EXT_INT-1:0] ext_int;

    integer seed;
    int     errs;
    int     tx_errs;
    int     checks;
    int     tx_checks;
    int     delivered;
    int     errs_mark;
    int     tests_done;
    logic [NOC_ADDR_W-1:0] exp_addr_q [$];
    logic [NOC_DATA_W-1:0] exp_data_q [$];
    logic [CHIPID_W-1:0]   exp_trg_q [$];

    `include "tb_model.svh"

    tile_top dut_i (
        .clk_pm_i         (clk_pm),
        .arst_n_i         (arst_n),
        .home_chipid_i    (home),
        .rx_wrreq_i       (rx_wrreq),
        .rx_mode_i        (rx_mode),
        .rx_addr_i        (rx_addr),
        .rx_bsel_i        (rx_bsel),
        .rx_data_i        (rx_data),
        .rx_src_chipid_i  (rx_src),
        .rx_trg_chipid_i  (rx_trg),
        .rx_stall_o       (rx_stall),
        .tx_wrreq_o       (tx_wrreq),
        .tx_mode_o        (tx_mode),
        .tx_addr_o        (tx_addr),
        .tx_data_o        (tx_data),
        .tx_trg_chipid_o  (tx_trg),
        .tx_src_chipid_o  (tx_src),
        .tx_stall_i       (tx_stall),
        .core_mem_en_i    (core_mem_en),
        .core_mem_wben_i  (core_mem_wben),
        .core_mem_addr_i  (core_mem_addr),
        .core_mem_wdata_i (core_mem_wdata),
        .core_mem_rdata_o (core_mem_rdata),
        .core_mem_stall_o (core_mem_stall),
        .core_en_o        (core_en),
        .ext_int_o        (ext_int)
    );

    initial begin
        clk_pm = 1'b0;
        forever #(CLK_PERIOD / 2) clk_pm = ~clk_pm;
    end

    function automatic logic [31:0] rand32();
        return $random(seed);
    endfunction

    // returns at the edge that takes the flit
    task automatic noc_send(input logic [NOC_MODE_W-1:0] mode, input logic [NOC_ADDR_W-1:0] addr,
                            input logic [NOC_BSEL_W-1:0] bsel, input logic [NOC_DATA_W-1:0] data,
                            input logic [CHIPID_W-1:0] src, input logic [CHIPID_W-1:0] trg);
        @(posedge clk_pm);
        rx_wrreq <= 1'b1;
        rx_mode  <= mode;
        rx_addr  <= addr;
        rx_bsel  <= bsel;
        rx_data  <= data;
        rx_src   <= src;
        rx_trg   <= trg;
        @(negedge clk_pm);
        while (rx_stall) @(negedge clk_pm);
        if (trg == HOME_ID) begin
            if (mode == MODE_MEM_READ || mode == MODE_REG_READ) begin
                exp_addr_q.push_back(addr);
                exp_data_q.push_back(expected_read(mode, addr));
                exp_trg_q.push_back(src);
            end
            if (mode == MODE_MEM_WRITE) begin
                merge_write(addr, bsel, data);
            end
            apply_reg_flit(mode, addr, data, src);
        end
        @(posedge clk_pm);
        rx_wrreq <= 1'b0;
    endtask

    task automatic core_access(input logic [NOC_BSEL_W-1:0] wben, input logic [NOC_ADDR_W-1:0] addr,
                               input logic [NOC_DATA_W-1:0] wdata);
        logic [NOC_DATA_W-1:0] expd;
        @(posedge clk_pm);
        core_mem_en    <= 1'b1;
        core_mem_wben  <= wben;
        core_mem_addr  <= addr;
        core_mem_wdata <= wdata;
        @(negedge clk_pm);
        while (core_mem_stall) @(negedge clk_pm);
        expd = model_spm[word_of(addr)];
        merge_write(addr, wben, wdata);
        @(posedge clk_pm);
        core_mem_en <= 1'b0;
        if (wben == '0) begin
            @(negedge clk_pm);  // cycle after acceptance
            checks++;
            if (core_mem_rdata !== expd) begin
                $display("ERR %0t: core read 0x%h gave 0x%h, expected 0x%h",
                         $time, addr, core_mem_rdata, expd);
                errs++;
            end
        end
    endtask

    task automatic wait_noc_idle();
        @(negedge clk_pm);
        while (rx_stall || exp_addr_q.size() != 0) @(negedge clk_pm);
    endtask

    task automatic watch_ext_int(input logic [NUM_EXT_INT-1:0] pattern);
        int hits [NUM_EXT_INT];
        for (int b = 0; b < NUM_EXT_INT; b++) hits[b] = 0;
        repeat (6) begin
            @(negedge clk_pm);
            for (int b = 0; b < NUM_EXT_INT; b++) if (ext_int[b]) hits[b]++;
        end
        for (int b = 0; b < NUM_EXT_INT; b++) begin
            checks++;
            if (hits[b] != int'(pattern[b])) begin
                $display("ERR %0t: ext_int[%0d] high %0d cycles, expected %0d",
                         $time, b, hits[b], pattern[b]);
                errs++;
            end
        end
    endtask

    task automatic check_core_en();
        @(negedge clk_pm);
        checks++;
        if (core_en !== model_core_en) begin
            $display("ERR %0t: core_en %b, expected %b", $time, core_en, model_core_en);
            errs++;
        end
    endtask

    task automatic finish_test(input string name);
        int n;
        n = errs + tx_errs - errs_mark;
        tests_done++;
        $display("test %0d %s: %s, %0d mismatches", tests_done, name, n == 0 ? "ok" : "FAILED", n);
        errs_mark = errs + tx_errs;
    endtask

    // every delivered tx flit against the oldest expected response
    initial begin
        logic [NOC_ADDR_W-1:0] e_addr;
        logic [NOC_DATA_W-1:0] e_data;
        logic [CHIPID_W-1:0]   e_trg;
        forever begin
            @(negedge clk_pm);
            if (tx_wrreq && !tx_stall) begin
                delivered++;
                tx_checks++;
                if (exp_addr_q.size() == 0) begin
                    $display("unexpected tx flit to chip 0x%h at time %0t", tx_trg.id, $time);
                    tx_errs++;
                end else begin
                    e_addr = exp_addr_q.pop_front();
                    e_data = exp_data_q.pop_front();
                    e_trg  = exp_trg_q.pop_front();
                    if (tx_mode !== MODE_READ_RESP || tx_addr !== e_addr || tx_data !== e_data
                        || tx_trg.id !== e_trg || tx_src.id !== HOME_ID) begin
                        $display("ERR %0t: tx %0d %h %h to %h from %h, expected %h %h to %h",
                                 $time, tx_mode, tx_addr, tx_data, tx_trg.id, tx_src.id,
                                 e_addr, e_data, e_trg);
                        tx_errs++;
                    end
                end
            end
        end
    end

    initial begin
        #(2 * RUN_CYCLES * CLK_PERIOD);
        $display("timeout: the run did not finish within %0d cycles", 2 * RUN_CYCLES);
        $display("Errors found");
        $finish;
    end

    initial begin
        logic [31:0] r;
        logic [7:0]  w;
        logic [7:0]  words [16];
        logic [NOC_DATA_W-1:0] held;
        int          d0;
        seed = 46;
        errs = 0;
        tx_errs = 0;
        checks = 0;
        tx_checks = 0;
        delivered = 0;
        errs_mark = 0;
        tests_done = 0;
        model_core_en = 1'b0;
        model_last_src = '0;
        home = HOME_ID;
        arst_n = 1'b0;
        rx_wrreq = 1'b0;
        rx_mode = '0;
        rx_addr = '0;
        rx_bsel = '0;
        rx_data = '0;
        rx_src = '0;
        rx_trg = '0;
        tx_stall = 1'b0;
        core_mem_en = 1'b0;
        core_mem_wben = '0;
        core_mem_addr = '0;
        core_mem_wdata = '0;
        repeat (8) @(posedge clk_pm);
        arst_n <= 1'b1;
        @(negedge clk_pm);
        checks++;
        if ({rx_stall, tx_wrreq, core_mem_stall, core_en, ext_int} !== '0) begin
            $display("ERR %0t: outputs not low after reset", $time);
            errs++;
        end

        for (int i = 0; i < 16; i++) begin
            r = rand32();
            words[i] = 8'(i * 16) | {4'h0, r[3:0]};
            noc_send(MODE_MEM_WRITE, {r[31:10], words[i], 2'b00}, 4'hF, rand32(),
                     r[23:16], HOME_ID);
            noc_send(MODE_MEM_WRITE, {r[31:10], words[i], 2'b00}, r[7:4], rand32(),
                     r[23:16], HOME_ID);
            noc_send(MODE_MEM_READ, {r[31:10], words[i], 2'b00}, 4'h0, 32'h0, r[15:8], HOME_ID);
        end
        wait_noc_idle();
        finish_test("noc write and read");

        for (int i = 0; i < 8; i++) begin
            r = rand32();
            w = 8'(200 + i);
            core_access(4'hF, {22'h0, w, 2'b00}, r);
            noc_send(MODE_MEM_READ, {22'h0, w, 2'b00}, 4'h0, 32'h0, r[7:0], HOME_ID);
            w = 8'(216 + i);
            noc_send(MODE_MEM_WRITE, {22'h0, w, 2'b00}, 4'hF, ~r, r[15:8], HOME_ID);
            wait_noc_idle();  // noc write lands before the core reads
            core_access(4'h0, {22'h0, w, 2'b00}, 32'h0);
        end
        finish_test("core and noc sharing");

        fork
            begin : noc_traffic
                logic [31:0] nr;
                logic [7:0]  nw;
                for (int i = 0; i < 32; i++) begin
                    nr = rand32();
                    nw = {1'b0, nr[6:0]};
                    if (!touched[nw] || nr[7]) begin
                        noc_send(MODE_MEM_WRITE, {nr[31:10], nw, 2'b00},
                                 touched[nw] ? nr[11:8] : 4'hF, rand32(), nr[19:12], HOME_ID);
                    end else begin
                        noc_send(MODE_MEM_READ, {nr[31:10], nw, 2'b00}, 4'h0, 32'h0,
                                 nr[19:12], HOME_ID);
                    end
                end
            end
            begin : core_traffic
                logic [31:0] cr;
                logic [7:0]  cw;
                logic [3:0]  cb;
                for (int i = 0; i < 32; i++) begin
                    cr = rand32();
                    cw = {1'b1, cr[6:0]};
                    cb = (cr[11:8] == 4'h0) ? 4'hF : cr[11:8];  // zero would be a read
                    if (!touched[cw] || cr[7]) begin
                        core_access(touched[cw] ? cb : 4'hF, {cr[31:10], cw, 2'b00}, rand32());
                    end else begin
                        core_access(4'h0, {cr[31:10], cw, 2'b00}, 32'h0);
                    end
                end
            end
        join
        wait_noc_idle();
        for (int i = 0; i < SPM_DEPTH; i++) begin
            if (touched[i]) begin
                noc_send(MODE_MEM_READ, {22'h0, 8'(i), 2'b00}, 4'h0, 32'h0, 8'(i), HOME_ID);
            end
        end
        wait_noc_idle();
        finish_test("concurrent traffic");

        noc_send(MODE_REG_WRITE, 32'h0, 4'hF, 32'h1, 8'h21, HOME_ID);
        check_core_en();
        noc_send(MODE_REG_READ, 32'h0, 4'h0, 32'h0, 8'h22, HOME_ID);
        noc_send(MODE_REG_WRITE, 32'h0, 4'hF, 32'h2, 8'h23, HOME_ID);
        check_core_en();
        for (int p = 1; p < 4; p++) begin
            noc_send(MODE_REG_WRITE, 32'h4, 4'hF, 32'(p), 8'h30, HOME_ID);
            watch_ext_int(2'(p));
        end
        noc_send(MODE_REG_READ, 32'h4, 4'h0, 32'h0, 8'h31, HOME_ID);  // reads zero
        r = rand32();
        noc_send(MODE_REG_WRITE, 32'h0, 4'hF, 32'h1, r[7:0], HOME_ID);
        noc_send(MODE_REG_READ, 32'h8, 4'h0, 32'h0, r[15:8], HOME_ID);
        noc_send(MODE_REG_READ, 32'h8, 4'h0, 32'h0, r[23:16], HOME_ID);
        noc_send(MODE_REG_READ, 32'hC, 4'h0, 32'h0, 8'h32, HOME_ID);
        wait_noc_idle();
        finish_test("register access");

        d0 = delivered;
        noc_send(MODE_MEM_WRITE, {22'h0, words[0], 2'b00}, 4'hF, ~model_spm[words[0]],
                 8'h40, OTHER_ID);
        noc_send(MODE_REG_WRITE, 32'h0, 4'hF, {31'h0, ~model_core_en}, 8'h41, OTHER_ID);
        noc_send(MODE_REG_WRITE, 32'h4, 4'hF, 32'h3, 8'h42, OTHER_ID);
        watch_ext_int(2'b00);
        check_core_en();
        noc_send(MODE_MEM_READ, {22'h0, words[0], 2'b00}, 4'h0, 32'h0, 8'h43, OTHER_ID);
        noc_send(MODE_REG_READ, 32'h8, 4'h0, 32'h0, 8'h44, OTHER_ID);
        repeat (6) @(negedge clk_pm);
        checks++;
        if (delivered != d0) begin
            $display("a flit for another chip produced a tx flit at time %0t", $time);
            errs++;
        end
        noc_send(MODE_REG_READ, 32'h8, 4'h0, 32'h0, 8'h45, HOME_ID);
        noc_send(MODE_MEM_READ, {22'h0, words[0], 2'b00}, 4'h0, 32'h0, 8'h46, HOME_ID);
        noc_send(MODE_REG_READ, 32'h0, 4'h0, 32'h0, 8'h47, HOME_ID);
        wait_noc_idle();
        finish_test("foreign target dropped");

        @(posedge clk_pm);
        tx_stall <= 1'b1;
        noc_send(MODE_MEM_READ, {22'h0, words[1], 2'b00}, 4'h0, 32'h0, 8'h50, HOME_ID);
        @(negedge clk_pm);
        while (!tx_wrreq) @(negedge clk_pm);
        held = tx_data;
        d0 = delivered;
        repeat (10) begin
            @(negedge clk_pm);
            checks++;
            if (!tx_wrreq || !rx_stall || tx_data !== held
                || tx_addr !== {22'h0, words[1], 2'b00} || tx_trg.id !== 8'h50) begin
                $display("ERR %0t: stalled response changed or rx_stall dropped", $time);
                errs++;
            end
        end
        @(posedge clk_pm);
        tx_stall <= 1'b0;
        wait_noc_idle();
        repeat (5) @(negedge clk_pm);
        checks++;
        if (delivered != d0 + 1) begin
            $display("stalled response delivered %0d times instead of once", delivered - d0);
            errs++;
        end
        finish_test("tx back-pressure");

        $display("tests %0d, checks %0d, tx flits %0d, errors %0d",
                 tests_done, checks + tx_checks, delivered, errs + tx_errs);
        if (errs + tx_errs == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// ==== sim.f ====
+incdir+testbench
src/tile_pkg.sv
src/tile_ifs.sv
src/spm_mem.sv
src/spm_arbiter.sv
src/tile_regfile.sv
src/noc_mem_ctrl.sv
src/tile_top.sv
testbench/tb_tile_top.sv

// ==== Makefile ====
SIM      := verilator
VFLAGS   := --binary --timing --timescale 1ns/1ps
TOP      := tb_tile_top
FILELIST := sim.f

OBJ_DIR  := obj_dir
BIN      := $(OBJ_DIR)/V$(TOP)
SRCS     := $(shell grep -v '^+' $(FILELIST)) testbench/tb_model.svh

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "No errors"

clean:
	rm -rf $(OBJ_DIR)
